// ==== nes_bus_core.f ====
+incdir+testbench
hdl/nes_bus_pkg.sv
hdl/nes_clock_enables.sv
hdl/oam_dmc_dma.sv
hdl/cpu_bus_arbiter.sv
hdl/nes_bus_core.sv
testbench/tb_nes_bus_core.sv

// ==== Makefile ====
FLIST = nes_bus_core.f
TOP   = tb_nes_bus_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	verilator --binary --assert -j 0 -f $(FLIST) --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== testbench/tb_tasks.svh ====
// Directed test tasks and bus helpers, included inside the testbench module
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Counts clocks up to the next CPU or PPU enable, sampled on the falling edge
task automatic wait_pulse(input logic sel_ppu, output int gap);
	gap = 0;
	do begin
		@(negedge clk);
		gap = gap + 1;
	end while (!(sel_ppu ? ppu_ce : cpu_ce));
endtask

// One CPU access, returns the data bus seen in the enable clk
task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] wdata, input logic rnw,
		output logic [7:0] rdata);
	@(posedge clk);
	cpu_bus <= '{addr, wdata, rnw};
	do @(negedge clk); while (!cpu_ce);
	rdata = cpu_din;
endtask

task automatic ntsc_cadence();
	int gap;
	int i;
	wait_pulse(1'b0, gap);  // Align
	for (i = 0; i < 50; i++) begin
		wait_pulse(1'b0, gap);
		assert (gap == 12) else value_mismatch("ntsc_cadence cpu_ce gap", 12, gap);
	end
	wait_pulse(1'b1, gap);
	for (i = 0; i < 150; i++) begin
		wait_pulse(1'b1, gap);
		assert (gap == 4) else value_mismatch("ntsc_cadence ppu_ce gap", 4, gap);
	end
endtask

task automatic pal_cadence();
	int gaps [$];
	int gap;
	int sum;
	int i;
	@(posedge clk);
	pal <= 1'b1;
	repeat (3) wait_pulse(1'b0, gap);  // Skip the realignment
	for (i = 0; i < 20; i++) begin
		wait_pulse(1'b0, gap);
		gaps.push_back(gap);
		assert (gap == 12 || gap == 16) else value_mismatch("pal_cadence cpu_ce gap", 12, gap);
	end
	// Any five cycles span 64 clocks, so one long cycle per group
	for (i = 0; i + 5 <= 20; i++) begin
		sum = gaps[i] + gaps[i + 1] + gaps[i + 2] + gaps[i + 3] + gaps[i + 4];
		assert (sum == 64) else value_mismatch("pal_cadence five cycle span", 64, sum);
	end
	@(posedge clk);
	pal <= 1'b0;
	repeat (2) wait_pulse(1'b0, gap);  // Back to NTSC timing
endtask

task automatic memory_path();
	logic [7:0] rdata;
	logic [7:0] expected;
	int         writes_before;
	writes_before = mem_write_count;
	bus_cycle(16'h0456, 8'h5a, 1'b0, rdata);
	@(negedge clk);  // Write lands on the closing edge
	assert (mem_write_count == writes_before + 1)
		else value_mismatch("memory_path write count", writes_before + 1, mem_write_count);
	assert (last_write_addr == 16'h0456)
		else value_mismatch("memory_path write addr", 32'h0456, 32'(last_write_addr));
	assert (last_write_data == 8'h5a)
		else value_mismatch("memory_path write data", 32'h5a, 32'(last_write_data));
	expected = mem[16'h0789];
	bus_cycle(16'h0789, 8'h00, 1'b1, rdata);
	assert (rdata == expected) else value_mismatch("memory_path read", 32'(expected), 32'(rdata));
	bus_cycle(io_base, 8'h00, 1'b1, rdata);  // Nothing answers, last byte floats
	assert (rdata == expected)
		else value_mismatch("memory_path open bus", 32'(expected), 32'(rdata));
endtask

task automatic joypad_port();
	logic [7:0] rdata;
	logic [7:0] ob;
	bus_cycle(16'h0123, 8'ha7, 1'b0, rdata);
	bus_cycle(16'h0123, 8'h00, 1'b1, rdata);  // Known open bus byte
	ob = 8'ha7;
	assert (rdata == ob) else value_mismatch("joypad_port setup read", 32'(ob), 32'(rdata));
	bus_cycle(joy1_reg, 8'h05, 1'b0, rdata);
	@(negedge clk);
	assert (joypad_strobe == 3'd5)
		else value_mismatch("joypad_port strobe", 5, 32'(joypad_strobe));
	bus_cycle(joy1_reg, 8'h00, 1'b1, rdata);
	assert (joypad_clock == 2'b01)
		else value_mismatch("joypad_port clock pad 1", 1, 32'(joypad_clock));
	assert (rdata == {ob[7:5], joypad1_data})
		else value_mismatch("joypad_port read pad 1", 32'({ob[7:5], joypad1_data}), 32'(rdata));
	@(negedge clk);
	assert (joypad_clock == 2'b00)
		else value_mismatch("joypad_port clock release", 0, 32'(joypad_clock));
	bus_cycle(joy2_reg, 8'h00, 1'b1, rdata);
	assert (joypad_clock == 2'b10)
		else value_mismatch("joypad_port clock pad 2", 2, 32'(joypad_clock));
	assert (rdata == {ob[7:5], joypad2_data})
		else value_mismatch("joypad_port read pad 2", 32'({ob[7:5], joypad2_data}), 32'(rdata));
endtask

// Page copy with the CPU parked on a read, optional DMC request once dmc_after bytes are out
task automatic sprite_copy(input string name, input logic [7:0] page, input int dmc_after);
	logic [7:0] expected [$];
	logic [7:0] rdata;
	int         i;
	for (i = 0; i < 256; i++)
		expected.push_back(mem[{page, 8'(i)}]);
	oam_log.delete();
	bus_cycle(oam_dma_reg, page, 1'b0, rdata);
	@(posedge clk);
	cpu_bus <= '{16'h0000, 8'h00, 1'b1};
	@(negedge clk);
	assert (pause_cpu) else abort_with({name, ": pause_cpu did not rise after the page write"});
	if (dmc_after >= 0) begin
		while (oam_log.size() < dmc_after) @(negedge clk);
		@(posedge clk);
		dmc_addr <= 16'h1234;
		dmc_req  <= 1'b1;
		do @(negedge clk); while (!dmc_ack);
		@(posedge clk);
		dmc_req <= 1'b0;  // Requester lets go once acknowledged
	end
	@(negedge clk);
	while (pause_cpu) @(negedge clk);
	assert (oam_log.size() == 256)
		else value_mismatch({name, " OAM write count"}, 256, oam_log.size());
	for (i = 0; i < 256; i++)
		assert (oam_log[i] == expected[i])
			else value_mismatch($sformatf("%s byte %0d", name, i), 32'(expected[i]),
				32'(oam_log[i]));
endtask

task automatic sprite_dma();
	int acks_before;
	acks_before = dmc_ack_count;
	sprite_copy("sprite_dma", 8'h03, -1);
	assert (dmc_ack_count == acks_before)
		else value_mismatch("sprite_dma stray dmc_ack", acks_before, dmc_ack_count);
endtask

task automatic dmc_during_sprite();
	int acks_before;
	int reads_before;
	acks_before  = dmc_ack_count;
	reads_before = dmc_read_count;
	sprite_copy("dmc_during_sprite", 8'h05, 40);
	assert (dmc_ack_count - acks_before == 1)
		else value_mismatch("dmc_during_sprite ack pulses", 1, dmc_ack_count - acks_before);
	assert (dmc_read_count - reads_before == 1)
		else value_mismatch("dmc_during_sprite reads", 1, dmc_read_count - reads_before);
endtask

`endif

// ==== testbench/tb_nes_bus_core.sv ====
// Testbench for the CPU bus fabric: clock, reset, memory model, bus monitors and directed test run
`default_nettype none
`timescale 1ns/100ps

module tb_nes_bus_core import nes_bus_pkg::*; ();

	// Clock budget per test, the watchdog allows three times the sum
	localparam int ntsc_clks     = 50 * 12 + 150 * 4;
	localparam int pal_clks      = 30 * 16;
	localparam int port_clks     = 20 * 12;
	localparam int sprite_clks   = 2 * (2 * 256 + 8) * 12;  // Plain copy plus copy with DMC
	localparam int watchdog_clks = 3 * (ntsc_clks + pal_clks + port_clks + sprite_clks);

	logic        clk = 1'b0;
	logic        reset;
	logic        pal;
	cpu_bus_t    cpu_bus;
	logic [7:0]  cpu_din;
	logic        pause_cpu;
	logic        cpu_ce;
	logic        ppu_ce;
	logic        dmc_req;
	logic [15:0] dmc_addr;
	logic        dmc_ack;
	mem_req_t    mem_req;
	logic [7:0]  mem_rdata;
	logic [4:0]  joypad1_data;
	logic [4:0]  joypad2_data;
	logic [2:0]  joypad_strobe;
	logic [1:0]  joypad_clock;

	logic [7:0]  mem [0:65535];      // 64 KB behind the bus
	logic [7:0]  oam_log [$];        // Bytes written to the OAM data port, in order
	int          mem_write_count = 0;
	logic [15:0] last_write_addr;
	logic [7:0]  last_write_data;
	int          dmc_ack_count = 0;  // Rising edges of dmc_ack
	int          dmc_read_count = 0; // Correct reads at dmc_addr during an ack
	logic        dmc_ack_q = 1'b0;

	always #50 clk = ~clk;  // 100 ns period

	nes_bus_core u_nes_bus_core (
		.clk           (clk),
		.reset         (reset),
		.pal           (pal),
		.cpu_bus       (cpu_bus),
		.cpu_din       (cpu_din),
		.pause_cpu     (pause_cpu),
		.cpu_ce        (cpu_ce),
		.ppu_ce        (ppu_ce),
		.dmc_req       (dmc_req),
		.dmc_addr      (dmc_addr),
		.dmc_ack       (dmc_ack),
		.mem_req       (mem_req),
		.mem_rdata     (mem_rdata),
		.joypad1_data  (joypad1_data),
		.joypad2_data  (joypad2_data),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock)
	);

	`include "tb_tasks.svh"

	assign mem_rdata = mem[mem_req.addr];  // Answers within the same clk

	// Memory model, random contents then write capture
	initial begin
		void'($urandom(32'h5039_0acc));
		for (int a = 0; a < 65536; a++)
			mem[16'(a)] = 8'($urandom);
		forever begin
			@(posedge clk);
			if (mem_req.write) begin
				mem[mem_req.addr] <= mem_req.wdata;
				mem_write_count   <= mem_write_count + 1;
				last_write_addr   <= mem_req.addr;
				last_write_data   <= mem_req.wdata;
				if (mem_req.addr == oam_data_reg)
					oam_log.push_back(mem_req.wdata);
			end
		end
	end

	// DMC monitor, counts grants and the read made in each
	always @(posedge clk) begin
		dmc_ack_q <= dmc_ack;
		if (dmc_ack && !dmc_ack_q)
			dmc_ack_count <= dmc_ack_count + 1;
		if (dmc_ack && cpu_ce && mem_req.read && mem_req.addr == dmc_addr
				&& cpu_din == mem[dmc_addr])
			dmc_read_count <= dmc_read_count + 1;
	end

	initial begin
		reset        = 1'b1;
		pal          = 1'b0;
		cpu_bus      = '{16'h0000, 8'h00, 1'b1};  // CPU idles in a read
		dmc_req      = 1'b0;
		dmc_addr     = 16'h0000;
		joypad1_data = 5'h0b;
		joypad2_data = 5'h14;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		ntsc_cadence();
		pal_cadence();
		memory_path();
		joypad_port();
		sprite_dma();
		dmc_during_sprite();
		$display("STATUS: PASS");
		$finish;
	end

	initial begin
		repeat (watchdog_clks) @(posedge clk);
		abort_with($sformatf("timeout: tests still running after %0d clocks", watchdog_clks));
	end

	task automatic abort_with(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic value_mismatch(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		abort_with($sformatf("mismatch in %s: expected 0x%0h, actual 0x%0h",
			test, expected, actual));
	endtask

endmodule

`default_nettype wire

// ==== hdl/nes_bus_core.sv ====
// CPU-side bus fabric top level: clock enables, sprite/DMC DMA and bus arbiter between CPU and memory
`default_nettype none
`timescale 1ns/100ps

module nes_bus_core import nes_bus_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        pal,
	input  cpu_bus_t    cpu_bus,       // From the external CPU
	output logic [7:0]  cpu_din,       // Read data back to the CPU
	output logic        pause_cpu,     // CPU ready, active high stall
	output logic        cpu_ce,
	output logic        ppu_ce,
	input  logic        dmc_req,
	input  logic [15:0] dmc_addr,
	output logic        dmc_ack,
	output mem_req_t    mem_req,
	input  logic [7:0]  mem_rdata,
	input  logic [4:0]  joypad1_data,
	input  logic [4:0]  joypad2_data,
	output logic [2:0]  joypad_strobe,
	output logic [1:0]  joypad_clock
);

	clk_en_t    clk_en;
	dma_bus_t   dma_bus;
	logic       sprite_trigger;
	logic [7:0] sprite_page;

	nes_clock_enables u_nes_clock_enables (
		.clk    (clk),
		.reset  (reset),
		.pal    (pal),
		.clk_en (clk_en)
	);

	assign cpu_ce = clk_en.cpu_ce;
	assign ppu_ce = clk_en.ppu_ce;

	oam_dmc_dma u_oam_dmc_dma (
		.clk            (clk),
		.reset          (reset),
		.clk_en         (clk_en),
		.sprite_trigger (sprite_trigger),
		.sprite_page    (sprite_page),
		.cpu_read       (cpu_bus.rnw),  // CPU keeps its read flag while stalled
		.read_data      (cpu_din),
		.dmc_req        (dmc_req),
		.dmc_addr       (dmc_addr),
		.dma_bus        (dma_bus),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	cpu_bus_arbiter u_cpu_bus_arbiter (
		.clk            (clk),
		.reset          (reset),
		.clk_en         (clk_en),
		.cpu_bus        (cpu_bus),
		.dma_bus        (dma_bus),
		.mem_rdata      (mem_rdata),
		.joypad1_data   (joypad1_data),
		.joypad2_data   (joypad2_data),
		.mem_req        (mem_req),
		.read_data      (cpu_din),
		.sprite_trigger (sprite_trigger),
		.sprite_page    (sprite_page),
		.joypad_strobe  (joypad_strobe),
		.joypad_clock   (joypad_clock)
	);

endmodule

`default_nettype wire

// ==== hdl/cpu_bus_arbiter.sv ====
// CPU/DMA bus merge with joypad and sprite DMA register decode, open-bus latch and CPU read mux
`default_nettype none
`timescale 1ns/100ps

module cpu_bus_arbiter import nes_bus_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  clk_en_t    clk_en,
	input  cpu_bus_t   cpu_bus,
	input  dma_bus_t   dma_bus,
	input  logic [7:0] mem_rdata,       // Valid in the same clk as the request
	input  logic [4:0] joypad1_data,
	input  logic [4:0] joypad2_data,
	output mem_req_t   mem_req,
	output logic [7:0] read_data,       // Data bus as seen by the CPU and DMA
	output logic       sprite_trigger,
	output logic [7:0] sprite_page,
	output logic [2:0] joypad_strobe,
	output logic [1:0] joypad_clock
);

	cpu_bus_t   bus;       // Bus after the DMA takeover
	logic       io_sel;    // Address inside the on-chip register window
	logic       joy1_sel;
	logic       joy2_sel;
	logic       dma_sel;
	logic       rd_cycle;  // Read access completing this clk
	logic       wr_cycle;  // Write access completing this clk
	logic [7:0] open_bus;  // Last value seen on the data bus

	// DMA wins whenever it drives the bus
	always_comb begin
		if (dma_bus.enable) begin
			bus.addr  = dma_bus.addr;
			bus.wdata = dma_bus.wdata;
			bus.rnw   = dma_bus.read;
		end else begin
			bus = cpu_bus;
		end
	end

	// Address decode
	assign io_sel   = (bus.addr >= io_base) && (bus.addr < io_limit);
	assign joy1_sel = (bus.addr == joy1_reg);
	assign joy2_sel = (bus.addr == joy2_reg);
	assign dma_sel  = (bus.addr == oam_dma_reg);

	// One access per CPU cycle
	assign rd_cycle = clk_en.cpu_ce && bus.rnw;
	assign wr_cycle = clk_en.cpu_ce && !bus.rnw;

	// Everything outside the register window goes to memory, PPU range included
	always_comb begin
		mem_req.addr  = bus.addr;
		mem_req.wdata = bus.wdata;
		mem_req.read  = rd_cycle && !io_sel;
		mem_req.write = wr_cycle && !io_sel;
	end

	// Page write to 4014 starts sprite DMA
	assign sprite_trigger = wr_cycle && dma_sel;
	assign sprite_page    = bus.wdata;

	// Strobe bits latch on 4016 writes
	always_ff @(posedge clk) begin
		if (reset)
			joypad_strobe <= 3'd0;
		else if (wr_cycle && joy1_sel)
			joypad_strobe <= bus.wdata[2:0];
	end

	// Each read shifts the pad
	assign joypad_clock = {rd_cycle && joy2_sel, rd_cycle && joy1_sel};

	// Read data mux
	always_comb begin
		if (joy1_sel)
			read_data = {open_bus[7:5], joypad1_data};  // Top bits float
		else if (joy2_sel)
			read_data = {open_bus[7:5], joypad2_data};
		else if (io_sel)
			read_data = open_bus;  // Nothing else answers here
		else
			read_data = mem_rdata;
	end

	// Bus capacitance keeps the last byte
	always_ff @(posedge clk) begin
		if (clk_en.cpu_ce)
			open_bus <= read_data;
	end

endmodule

`default_nettype wire

// ==== hdl/oam_dmc_dma.sv ====
// Sprite OAM DMA and DMC sample fetch engine; takes the CPU bus and stalls the CPU while it runs
`default_nettype none
`timescale 1ns/100ps

module oam_dmc_dma import nes_bus_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  clk_en_t     clk_en,
	input  logic        sprite_trigger,  // Write to the sprite DMA register this cycle
	input  logic [7:0]  sprite_page,     // Source page, high byte of the copy address
	input  logic        cpu_read,        // CPU is in a read cycle
	input  logic [7:0]  read_data,       // Byte read on the bus this cycle
	input  logic        dmc_req,         // Held until dmc_ack
	input  logic [15:0] dmc_addr,
	output dma_bus_t    dma_bus,
	output logic        dmc_ack,         // Whole cycle of the DMC read
	output logic        pause_cpu
);

	// Sprite states
	localparam logic [1:0] spr_idle = 2'd0;
	localparam logic [1:0] spr_wait = 2'd1;  // Bus requested, CPU still finishing
	localparam logic [1:0] spr_copy = 2'd3;  // Read on even, write on odd

	logic        dmc_state;   // Granted, read runs in the next even cycle
	logic [1:0]  spr_state;
	logic [15:0] spr_addr;    // page:index of the next source byte
	logic [7:0]  spr_byte;    // Byte on its way to OAM
	logic [8:0]  next_index;  // Bit 8 marks the end of the page
	logic        odd;

	assign odd        = clk_en.odd_cycle;
	assign next_index = {1'b0, spr_addr[7:0]} + 9'd1;
	assign dmc_ack    = dmc_state && !odd;

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= 1'b0;
			spr_state <= spr_idle;
		end else if (clk_en.cpu_ce) begin
			// DMC grant only on an even read cycle
			if (!dmc_state && dmc_req && cpu_read && !odd)
				dmc_state <= 1'b1;
			if (dmc_ack)
				dmc_state <= 1'b0;  // Single byte, done

			if (sprite_trigger)
				spr_state <= spr_wait;
			else if (spr_state == spr_wait && cpu_read && odd)
				spr_state <= spr_copy;  // Start so the first read lands on even
			else if (spr_state == spr_copy && dmc_ack)
				spr_state <= spr_wait;  // DMC stole the read, next odd slot is idle
			else if (spr_state == spr_copy && odd && next_index[8])
				spr_state <= spr_idle;  // 256th write done
		end
	end

	// Source address and byte latch
	always_ff @(posedge clk) begin
		if (clk_en.cpu_ce) begin
			if (sprite_trigger)
				spr_addr <= {sprite_page, 8'h00};
			else if (spr_state == spr_copy && odd)
				spr_addr[7:0] <= next_index[7:0];  // Step after each write
			if (spr_state == spr_copy && !odd && !dmc_ack)
				spr_byte <= read_data;
		end
	end

	always_comb begin
		dma_bus.enable = dmc_ack || spr_state[1];
		dma_bus.read   = !odd;     // Reads on even, OAM writes on odd
		dma_bus.wdata  = spr_byte;
		if (dmc_ack)
			dma_bus.addr = dmc_addr;
		else if (!odd)
			dma_bus.addr = spr_addr;
		else
			dma_bus.addr = oam_data_reg;
	end

	// CPU halts for both engines, DMC as soon as it asks
	assign pause_cpu = spr_state[0] || dmc_req;

endmodule

`default_nettype wire

// ==== hdl/nes_clock_enables.sv ====
// Master clock divider giving CPU/PPU clock enables and the even/odd CPU cycle flag, NTSC or PAL
`default_nettype none
`timescale 1ns/100ps

module nes_clock_enables import nes_bus_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    pal,     // 1 selects the PAL 3.2 PPU clocks per CPU clock ratio
	output clk_en_t clk_en
);

	logic [3:0] div_cpu;       // Position in the CPU cycle, 1 to 12
	logic [2:0] div_ppu;       // Position in the PPU cycle, 1 to 4
	logic [2:0] pal_cnt;       // CPU cycle within a PAL group
	logic       stretch_done;  // Extra PPU period of the long cycle already spent
	logic       last_pal;      // Previous pal, for realign on change
	logic       odd_cycle;
	logic       cpu_ce;
	logic       ppu_ce;
	logic       hold_cpu;

	assign cpu_ce = (div_cpu == 4'(cpu_div_n));
	assign ppu_ce = (div_ppu == 3'(ppu_div_n));

	// Fifth PAL cycle: freeze the CPU divider for the first PPU period
	assign hold_cpu = pal && (pal_cnt == 3'(pal_stretch_period - 1)) && !stretch_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu      <= 4'd1;
			div_ppu      <= 3'd1;
			pal_cnt      <= 3'd0;
			stretch_done <= 1'b0;
			last_pal     <= pal;
			odd_cycle    <= 1'b1;
		end else begin
			last_pal <= pal;
			if (last_pal != pal) begin
				// Standard changed, start over aligned like after reset
				div_cpu      <= 4'd1;
				div_ppu      <= 3'd1;
				pal_cnt      <= 3'd0;
				stretch_done <= 1'b0;
			end else begin
				if (!hold_cpu)
					div_cpu <= cpu_ce ? 4'd1 : div_cpu + 4'd1;
				div_ppu <= ppu_ce ? 3'd1 : div_ppu + 3'd1;

				if (hold_cpu && ppu_ce)
					stretch_done <= 1'b1;  // Hold ends after one PPU period
				else if (cpu_ce)
					stretch_done <= 1'b0;

				// Group counter only runs in PAL mode
				if (cpu_ce && pal)
					pal_cnt <= (pal_cnt == 3'(pal_stretch_period - 1)) ? 3'd0 : pal_cnt + 3'd1;
			end

			if (cpu_ce)
				odd_cycle <= ~odd_cycle;
		end
	end

	// Both dividers share the same phase, so the long cycle keeps PPU ticks aligned
	assign clk_en.cpu_ce    = cpu_ce;
	assign clk_en.ppu_ce    = ppu_ce;
	assign clk_en.odd_cycle = odd_cycle;

endmodule

`default_nettype wire

// ==== hdl/nes_bus_pkg.sv ====
// Shared timing constants, CPU address map and bus structs; imported by every block and the testbench
`default_nettype none

package nes_bus_pkg;

	// Master clock dividers
	localparam int unsigned cpu_div_n          = 12;  // Master clocks per CPU cycle
	localparam int unsigned ppu_div_n          = 4;   // Master clocks per PPU cycle
	localparam int unsigned pal_stretch_period = 5;   // CPU cycles per PAL group, last one is long

	// Registers decoded on the CPU bus
	localparam logic [15:0] oam_dma_reg  = 16'h4014;  // Sprite DMA page write
	localparam logic [15:0] oam_data_reg = 16'h2004;  // PPU OAM data port, sprite DMA target
	localparam logic [15:0] joy1_reg     = 16'h4016;  // Joypad 1 read, strobe write
	localparam logic [15:0] joy2_reg     = 16'h4017;  // Joypad 2 read

	// Internal register window, served on chip and never sent to memory
	localparam logic [15:0] io_base  = 16'h4000;
	localparam logic [15:0] io_limit = 16'h4018;  // First address past the window

	// Plain CPU bus, also used for the bus after the DMA merge
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        rnw;    // 1 = read, 0 = write
	} cpu_bus_t;

	// One access per CPU cycle to external memory
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        read;   // Single clk strobe
		logic        write;  // Single clk strobe
	} mem_req_t;

	// Clock enables from the master clock divider
	typedef struct packed {
		logic cpu_ce;     // Last master clock of a CPU cycle
		logic ppu_ce;     // Last master clock of a PPU cycle
		logic odd_cycle;  // Current CPU cycle is odd
	} clk_en_t;

	// DMA side of the bus
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        read;    // 1 = read, 0 = write
		logic        enable;  // DMA owns the bus this cycle
	} dma_bus_t;

endpackage

`default_nettype wire
